// ==== verilog/sd_proto_pkg.sv ====
package sd_proto_pkg;

  localparam logic [6:0] crc7_poly = 7'h09; // x^7 + x^3 + 1.
  localparam logic [5:0] hdr_bits  = 6'd40; // start, index and argument.

  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
  } cmd_req_t;

  typedef struct packed {
    logic [1:0]  start_bits; // always 2'b01.
    logic [5:0]  index;
    logic [31:0] arg;
    logic [6:0]  crc7;
    logic        end_bit;
  } cmd_fields_t;

  // bytes[5] is the first byte on the wire.
  typedef union packed {
    cmd_fields_t     fields;
    logic [5:0][7:0] bytes;
  } cmd_frame_u;

  typedef struct packed {
    logic start; // zero in a valid response.
    logic parameter_error;
    logic address_error;
    logic erase_seq_error;
    logic com_crc_error;
    logic illegal_command;
    logic erase_reset;
    logic in_idle;
  } r1_flags_t;

  typedef union packed {
    logic [7:0] raw;
    r1_flags_t  flags;
  } r1_u;

  typedef struct packed {
    logic       timeout;
    logic [5:0] index;
    r1_u        r1;
  } cmd_result_t;

endpackage

// ==== verilog/sd_link_pkg.sv ====
package sd_link_pkg;

  localparam int sck_half   = 4; // 125 gives 400 kHz.
  localparam int sck_cnt_w  = $clog2(sck_half + 1);
  localparam int ncr_max    = 8; // card may idle this many bytes before R1.
  localparam int poll_cnt_w = $clog2(ncr_max + 1);

  typedef enum logic [2:0] {
    dbg_last_result   = 3'd0,
    dbg_cmd_count     = 3'd1,
    dbg_err_count     = 3'd2,
    dbg_timeout_count = 3'd3,
    dbg_flags         = 3'd4,
    dbg_state         = 3'd5
  } dbg_sel_t;

  typedef struct packed {
    logic [7:0]                cmd_count;
    logic [7:0]                err_count;
    logic [7:0]                timeout_count;
    sd_proto_pkg::cmd_result_t last_result;
    logic [6:0]                flags_seen; // sticky or of r1[6:0].
  } dbg_status_t;

endpackage

// ==== verilog/sd_cmd_framer.sv ====
`timescale 1ns/1ps

module sd_cmd_framer (
  input  logic                     clock_100M,
  input  logic                     reset,
  input  logic                     req_valid,
  input  sd_proto_pkg::cmd_req_t   req,
  output logic                     active,
  output logic                     frame_valid,
  output sd_proto_pkg::cmd_frame_u frame
);

  logic [39:0] hdr; // rotates back to its start after 40 shifts.
  logic [6:0]  crc;
  logic [5:0]  bit_cnt;
  logic        crc_fb;
  logic        shifting;
  logic        emit;

  assign crc_fb   = hdr[39] ^ crc[6];
  assign shifting = active && (bit_cnt != sd_proto_pkg::hdr_bits);
  assign emit     = active && (bit_cnt == sd_proto_pkg::hdr_bits) && !frame_valid;

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      active      <= 1'b0;
      frame_valid <= 1'b0;
      bit_cnt     <= '0;
    end else begin
      frame_valid <= emit;
      if (!active) begin
        if (req_valid) begin
          active  <= 1'b1;
          bit_cnt <= '0;
        end
      end else if (shifting) begin
        bit_cnt <= bit_cnt + 6'd1;
      end else if (frame_valid) begin
        active <= 1'b0; // held through the frame strobe.
      end
    end
  end

  // serial crc7 with msb first.
  always_ff @(posedge clock_100M) begin
    if (!active && req_valid) begin
      hdr <= {2'b01, req.index, req.arg};
      crc <= '0;
    end else if (shifting) begin
      hdr <= {hdr[38:0], hdr[39]};
      crc <= {crc[5:0], 1'b0} ^ (crc_fb ? sd_proto_pkg::crc7_poly : 7'h00);
    end
  end

  always_ff @(posedge clock_100M) begin
    if (emit) begin
      frame.fields.start_bits <= hdr[39:38];
      frame.fields.index      <= hdr[37:32];
      frame.fields.arg        <= hdr[31:0];
      frame.fields.crc7       <= crc;
      frame.fields.end_bit    <= 1'b1;
    end
  end

endmodule

// ==== verilog/sd_spi_engine.sv ====
`timescale 1ns/1ps

module sd_spi_engine (
  input  logic                      clock_100M,
  input  logic                      reset,
  input  logic                      frame_valid,
  input  sd_proto_pkg::cmd_frame_u  frame,
  input  logic                      miso,
  output logic                      active,
  output logic                      cs,
  output logic                      sck,
  output logic                      mosi,
  output logic                      res_valid,
  output sd_proto_pkg::cmd_result_t res
);

  typedef enum logic [1:0] {idle, send, poll, finish} state_t;

  state_t                             state;
  sd_proto_pkg::cmd_frame_u           frame_q;
  logic [sd_link_pkg::sck_cnt_w-1:0]  half_cnt;
  logic [sd_link_pkg::poll_cnt_w-1:0] poll_cnt;
  logic [2:0]                         bit_cnt;
  logic [2:0]                         byte_idx; // byte now on the wire.
  logic [7:0]                         tx;
  logic [7:0]                         rx;
  logic                               half_tick;
  logic                               rise;
  logic                               fall;
  logic                               byte_done;
  logic                               resp_end;

  assign half_tick = (int'(half_cnt) == sd_link_pkg::sck_half - 1);
  assign rise      = half_tick && !sck;
  assign fall      = half_tick && sck;
  assign byte_done = fall && (bit_cnt == 3'd7);
  assign resp_end  = !rx[7] || (int'(poll_cnt) == sd_link_pkg::ncr_max);
  assign active    = (state != idle);
  assign mosi      = tx[7]; // tx only moves on a falling edge.

  always_ff @(posedge clock_100M) begin
    if (reset || state == idle || half_tick) half_cnt <= '0;
    else half_cnt <= half_cnt + 1'b1;
  end

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      state     <= idle;
      cs        <= 1'b1;
      sck       <= 1'b0;
      tx        <= 8'hFF;
      res_valid <= 1'b0;
      bit_cnt   <= '0;
      byte_idx  <= '0;
      poll_cnt  <= '0;
    end else begin
      res_valid <= 1'b0;
      case (state)
        idle: if (frame_valid) begin
          state    <= send;
          cs       <= 1'b0;
          tx       <= frame.bytes[5];
          bit_cnt  <= '0;
          byte_idx <= 3'd5;
        end
        send, poll: begin
          if (half_tick) sck <= ~sck;
          if (fall) begin
            bit_cnt <= bit_cnt + 3'd1;
            tx      <= {tx[6:0], 1'b1};
          end
          if (byte_done) begin
            if (state == send && byte_idx != 3'd0) begin
              byte_idx <= byte_idx - 3'd1;
              tx       <= frame_q.bytes[byte_idx - 3'd1];
            end else if (state == send) begin
              state    <= poll;
              poll_cnt <= '0;
            end else if (resp_end) begin
              state <= finish;
            end else begin
              poll_cnt <= poll_cnt + 1'b1;
            end
          end
        end
        finish: if (half_tick) begin
          state     <= idle; // cs back up half a period late.
          cs        <= 1'b1;
          res_valid <= 1'b1;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock_100M) begin
    if (state == idle && frame_valid) frame_q <= frame;
    if (rise) rx <= {rx[6:0], miso};
    if (state == poll && byte_done && resp_end) begin
      res.timeout <= rx[7];
      res.index   <= frame_q.fields.index;
      res.r1.raw  <= rx[7] ? 8'hFF : rx;
    end
  end

endmodule

// ==== verilog/sd_resp_decoder.sv ====
`timescale 1ns/1ps

module sd_resp_decoder (
  input  logic                      clock_100M,
  input  logic                      reset,
  input  logic                      res_valid,
  input  sd_proto_pkg::cmd_result_t res,
  output logic                      done,
  output sd_proto_pkg::cmd_result_t result,
  output sd_link_pkg::dbg_status_t  status
);

  logic is_error;

  // in_idle and erase_reset are normal states.
  assign is_error = !res.timeout && (res.r1.flags.parameter_error ||
                                     res.r1.flags.address_error   ||
                                     res.r1.flags.erase_seq_error ||
                                     res.r1.flags.com_crc_error   ||
                                     res.r1.flags.illegal_command);

  assign result = status.last_result;

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      done   <= 1'b0;
      status <= '0;
    end else begin
      done <= res_valid;
      if (res_valid) begin
        status.last_result <= res;
        status.cmd_count   <= status.cmd_count + 8'd1;
        if (res.timeout) begin
          status.timeout_count <= status.timeout_count + 8'd1;
        end else begin
          status.flags_seen <= status.flags_seen | res.r1.raw[6:0]; // no r1 on timeout.
        end
        if (is_error) status.err_count <= status.err_count + 8'd1;
      end
    end
  end

endmodule

// ==== verilog/sd_debug_select.sv ====
`timescale 1ns/1ps

module sd_debug_select (
  input  sd_link_pkg::dbg_sel_t    sel,
  input  sd_link_pkg::dbg_status_t status,
  input  logic                     busy,
  output logic [15:0]              led
);

  always_comb begin
    case (sel)
      sd_link_pkg::dbg_last_result: begin
        led = {1'b0, status.last_result}; // timeout, index, r1.
      end
      sd_link_pkg::dbg_cmd_count: begin
        led = {8'h00, status.cmd_count};
      end
      sd_link_pkg::dbg_err_count: begin
        led = {8'h00, status.err_count};
      end
      sd_link_pkg::dbg_timeout_count: begin
        led = {8'h00, status.timeout_count};
      end
      sd_link_pkg::dbg_flags: begin
        led = {9'h000, status.flags_seen};
      end
      sd_link_pkg::dbg_state: begin
        led = {15'h0000, busy};
      end
      default: led = 16'h0000;
    endcase
  end

endmodule

// ==== verilog/sd_spi_top.sv ====
`timescale 1ns/1ps

module sd_spi_top (
  input  logic                      clock_100M,
  input  logic                      reset,
  input  logic                      req_valid,
  input  sd_proto_pkg::cmd_req_t    req,
  input  logic                      miso,
  input  logic [2:0]                sw,
  output logic                      busy,
  output logic                      done,
  output sd_proto_pkg::cmd_result_t result,
  output logic                      cs,
  output logic                      sck,
  output logic                      mosi,
  output logic [15:0]               led
);

  logic                      framer_active;
  logic                      engine_active;
  logic                      frame_valid;
  sd_proto_pkg::cmd_frame_u  frame;
  logic                      res_valid;
  sd_proto_pkg::cmd_result_t res;
  sd_link_pkg::dbg_status_t  status;

  // res_valid means done is due next cycle.
  assign busy = framer_active | engine_active | res_valid;

  sd_cmd_framer framer (
    .clock_100M  (clock_100M),
    .reset       (reset),
    .req_valid   (req_valid & ~busy), // strobes while busy are dropped.
    .req         (req),
    .active      (framer_active),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  sd_spi_engine engine (
    .clock_100M  (clock_100M),
    .reset       (reset),
    .frame_valid (frame_valid),
    .frame       (frame),
    .miso        (miso),
    .active      (engine_active),
    .cs          (cs),
    .sck         (sck),
    .mosi        (mosi),
    .res_valid   (res_valid),
    .res         (res)
  );

  sd_resp_decoder decoder (
    .clock_100M (clock_100M),
    .reset      (reset),
    .res_valid  (res_valid),
    .res        (res),
    .done       (done),
    .result     (result),
    .status     (status)
  );

  sd_debug_select debug_select (
    .sel    (sd_link_pkg::dbg_sel_t'(sw)),
    .status (status),
    .busy   (busy),
    .led    (led)
  );

endmodule

// ==== tb/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model (
  input  logic                   cs,
  input  logic                   sck,
  input  logic                   mosi,
  input  sd_proto_pkg::cmd_req_t exp_req, // request the next frame must carry.
  output logic                   miso,
  output int                     frames,
  output int                     frame_errors,
  output int                     drawn_delay, // 0xFF bytes before r1.
  output sd_proto_pkg::r1_u      drawn_r1
);

  logic [47:0]              rx_bits;
  sd_proto_pkg::cmd_frame_u rx_frame;
  int                       bit_count;
  logic                     resp_bits[$];

  // remainder of hdr * x^7 by long division.
  function automatic logic [6:0] crc7_of(input logic [39:0] hdr);
    logic [46:0] rem;
    rem = {hdr, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) rem[i -: 8] = rem[i -: 8] ^ {1'b1, sd_proto_pkg::crc7_poly};
    end
    return rem[6:0];
  endfunction

  task automatic report_frame_fault(input string what);
    $display("card, frame %0d: %s", frames, what);
    frame_errors++;
  endtask

  task automatic check_frame();
    rx_frame = rx_bits;
    if (rx_frame.fields.start_bits != 2'b01) report_frame_fault("start bits are not 01");
    if (rx_frame.fields.index != exp_req.index) report_frame_fault("wrong command index");
    if (rx_frame.fields.arg != exp_req.arg) report_frame_fault("wrong argument");
    if (rx_frame.fields.crc7 != crc7_of({2'b01, exp_req.index, exp_req.arg})) begin
      report_frame_fault("crc7 does not match the header");
    end
    if (!rx_frame.fields.end_bit) report_frame_fault("end bit is not set");
  endtask

  initial begin
    miso         = 1'b1;
    frames       = 0;
    frame_errors = 0;
    drawn_delay  = 0;
    drawn_r1     = '0;
    bit_count    = 0;
    forever begin
      @(posedge sck or negedge sck or posedge cs);
      if (cs !== 1'b0) begin
        resp_bits.delete(); // engine finished or gave up.
        bit_count = 0;
        miso      = 1'b1;
      end else if (sck) begin
        rx_bits = {rx_bits[46:0], mosi};
        bit_count++;
        if (bit_count > 48 && !mosi) report_frame_fault("mosi low during a poll byte");
        if (bit_count == 48) begin
          check_frame();
          drawn_delay  = $urandom_range(10, 0);
          drawn_r1.raw = 8'($urandom_range(127, 0)); // start bit clear.
          repeat (drawn_delay * 8) resp_bits.push_back(1'b1);
          for (int i = 7; i >= 0; i--) resp_bits.push_back(drawn_r1.raw[i]);
          frames++;
        end
      end else if (resp_bits.size() > 0) begin
        miso = resp_bits.pop_front(); // mode 0 changes miso on falling sck.
      end else begin
        miso = 1'b1;
      end
    end
  end

endmodule

// ==== tb/tb_sd_spi_top.sv ====
`timescale 1ns/1ps

module tb_sd_spi_top;

  localparam int n_cmds = 200;
  localparam int watchdog_cycles =
    n_cmds * (41 + 16 * sd_link_pkg::sck_half * 17 + 20) + 2000;

  logic                      clock_100M;
  logic                      reset;
  logic                      req_valid;
  sd_proto_pkg::cmd_req_t    req;
  sd_proto_pkg::cmd_req_t    exp_req; // last accepted request.
  logic                      miso;
  logic [2:0]                sw;
  logic                      busy;
  logic                      done;
  sd_proto_pkg::cmd_result_t result;
  logic                      cs;
  logic                      sck;
  logic                      mosi;
  logic [15:0]               led;
  int                        frames;
  int                        frame_errors;
  int                        drawn_delay;
  sd_proto_pkg::r1_u         drawn_r1;
  int                        frames_logged = 0;
  int                        done_count = 0;
  sd_proto_pkg::cmd_result_t exp_q[$];
  sd_proto_pkg::cmd_result_t last_exp;
  logic [15:0]               exp_led[8];
  int                        model_cmds;
  int                        model_errs;
  int                        model_timeouts;
  logic [6:0]                model_flags;

  sd_spi_top uut (.*);

  sd_card_model card (.*);

  initial clock_100M = 1'b0;
  always #5 clock_100M = ~clock_100M;

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input sd_proto_pkg::cmd_result_t got,
                              input sd_proto_pkg::cmd_result_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_led(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_views();
    for (int s = 0; s < 8; s++) begin
      sw = 3'(s);
      @(negedge clock_100M);
      check_led($sformatf("led view %0d", s), led, exp_led[s]);
    end
  endtask

  // lands in the framer or in the engine phase.
  task automatic drive_ignored_strobe();
    repeat ($urandom_range(400, 1)) @(negedge clock_100M);
    check_led("led", led, 16'h0001); // busy bit of the state view.
    req.index = 6'($urandom_range(63, 0));
    req.arg   = $urandom();
    req_valid = 1'b1;
    @(negedge clock_100M);
    req_valid = 1'b0;
  endtask

  // one expected result per frame the card answered.
  always @(negedge clock_100M) begin
    if (frames != frames_logged) begin
      frames_logged++;
      if (drawn_delay > sd_link_pkg::ncr_max) begin
        exp_q.push_back(sd_proto_pkg::cmd_result_t'({1'b1, exp_req.index, 8'hFF}));
      end else begin
        exp_q.push_back(sd_proto_pkg::cmd_result_t'({1'b0, exp_req.index, drawn_r1.raw}));
      end
    end
    if (done) done_count++;
    if (frame_errors != 0) begin
      $display("card model received a malformed command frame");
      abort_run();
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock_100M);
    $display("run hung, no end after %0d cycles", watchdog_cycles);
    abort_run();
  end

  initial begin
    void'($urandom(32'hd2059500));
    reset          = 1'b1;
    req_valid      = 1'b0;
    req            = '0;
    exp_req        = '0;
    sw             = 3'd0;
    model_cmds     = 0;
    model_errs     = 0;
    model_timeouts = 0;
    model_flags    = '0;
    repeat (3) @(posedge clock_100M);
    @(negedge clock_100M);
    reset = 1'b0;
    check_bit("cs", cs, 1'b1);
    check_bit("busy", busy, 1'b0);
    check_bit("sck", sck, 1'b0);
    check_bit("mosi", mosi, 1'b1);
    for (int s = 0; s < 8; s++) exp_led[s] = 16'h0000;
    check_views();
    sw = 3'(sd_link_pkg::dbg_state);
    for (int n = 0; n < n_cmds; n++) begin
      repeat ($urandom_range(3, 0)) @(negedge clock_100M);
      exp_req.index = 6'($urandom_range(63, 0));
      exp_req.arg   = $urandom();
      req           = exp_req;
      req_valid     = 1'b1;
      @(negedge clock_100M);
      req_valid = 1'b0;
      check_bit("busy", busy, 1'b1);
      if ($urandom_range(2, 0) == 0) drive_ignored_strobe();
      do begin
        @(negedge clock_100M);
        if (done !== 1'b1) check_bit("busy", busy, 1'b1);
      end while (done !== 1'b1);
      if (exp_q.size() <= n) begin
        $display("done pulsed for command %0d but the card saw no frame for it", n);
        abort_run();
      end
      last_exp = exp_q[n];
      check_result("result", result, last_exp);
      model_cmds++;
      if (last_exp.timeout) begin
        model_timeouts++;
      end else begin
        model_flags = model_flags | last_exp.r1.raw[6:0];
        if (|last_exp.r1.raw[6:2]) model_errs++; // parameter down to illegal command.
      end
    end
    repeat (2) @(negedge clock_100M);
    exp_led[0] = {1'b0, last_exp};
    exp_led[1] = 16'(model_cmds);
    exp_led[2] = 16'(model_errs);
    exp_led[3] = 16'(model_timeouts);
    exp_led[4] = {9'h000, model_flags};
    check_views();
    if (frames != n_cmds || done_count != n_cmds) begin
      $display("card saw %0d frames and done pulsed %0d times for %0d commands",
               frames, done_count, n_cmds);
      abort_run();
    end
    if (frame_errors == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// ==== flist.f ====
verilog/sd_proto_pkg.sv
verilog/sd_link_pkg.sv
verilog/sd_cmd_framer.sv
verilog/sd_spi_engine.sv
verilog/sd_resp_decoder.sv
verilog/sd_debug_select.sv
verilog/sd_spi_top.sv
tb/sd_card_model.sv
tb/tb_sd_spi_top.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/Vtb_sd_spi_top: flist.f $(wildcard verilog/*.sv tb/*.sv)
	verilator --binary --timing -j 0 --top-module tb_sd_spi_top -f flist.f

run: obj_dir/Vtb_sd_spi_top
	./obj_dir/Vtb_sd_spi_top

lint:
	verilator --lint-only --timing -Wall --top-module sd_spi_top -f flist.f
	verilator --lint-only --timing -Wall --top-module tb_sd_spi_top -f flist.f

clean:
	rm -rf obj_dir
